//--- hdl/pcm_pkg.sv
`default_nettype none

package pcm_pkg;

    localparam int num_ch = 4;
    localparam int rom_aw = 21;

    typedef logic signed [11:0] ch_snd_t;
    typedef logic signed [13:0] mix_snd_t;
    typedef logic        [ 6:0] pan_gain_t;

    // sound CPU register map
    localparam logic [5:0] reg_keyon      = 6'h28;
    localparam logic [5:0] reg_status     = 6'h29;
    localparam logic [5:0] reg_loop_adpcm = 6'h2A;
    localparam logic [5:0] reg_pan01      = 6'h2C;
    localparam logic [5:0] reg_pan23      = 6'h2D;
    localparam logic [5:0] reg_rom_rd     = 6'h2E;
    localparam logic [5:0] reg_mode       = 6'h2F;

    // first byte of each field in the channel bank
    localparam int ch_pitch  = 0;
    localparam int ch_length = 2;
    localparam int ch_start  = 4;
    localparam int ch_volume = 7;

    // pan code to gain, code 0 is silent on both sides
    localparam pan_gain_t pan_left [8] = '{
        7'd0, 7'd127, 7'd116, 7'd104, 7'd90, 7'd73, 7'd52, 7'd0
    };
    localparam pan_gain_t pan_right [8] = '{
        7'd0, 7'd0, 7'd52, 7'd73, 7'd90, 7'd104, 7'd116, 7'd127
    };

endpackage

`default_nettype wire

//--- hdl/pcm_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pcm_regs import pcm_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // main CPU
    input  logic              ma0,
    input  logic              mrdnw,
    input  logic              mcs,
    input  logic [7:0]        mdout,
    output logic [7:0]        mdin,
    // sound CPU
    input  logic [5:0]        addr,
    input  logic              wr_n,
    input  logic              rd_n,
    input  logic              cs,
    input  logic [7:0]        din,
    output logic [7:0]        dout,
    // channel side
    input  logic [num_ch-1:0] over,
    input  logic [7:0]        rom0_data,
    output logic [num_ch-1:0] ch_we,
    output logic [num_ch-1:0] keyon,
    output logic [num_ch-1:0] loop,
    output logic [num_ch-1:0] adpcm_en,
    output logic              mix_en,
    output pan_gain_t         pan_l [num_ch],
    output pan_gain_t         pan_r [num_ch]
);
    logic [7:0] pm2s [2];
    logic [7:0] ps2m [2];
    logic [2:0] pan_code [num_ch];
    logic [1:0] mode;

    assign mix_en = mode[1];

    // main CPU side of the mailbox
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pm2s[0] <= '0;
            pm2s[1] <= '0;
            mdin    <= '0;
        end else if (mcs) begin
            mdin <= ps2m[ma0];
            if (!mrdnw) begin
                pm2s[ma0] <= mdout;
            end
        end
    end

    // sound CPU writes and registered readback
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ps2m[0]  <= '0;
            ps2m[1]  <= '0;
            keyon    <= '0;
            loop     <= '0;
            adpcm_en <= '0;
            mode     <= '0;
            dout     <= '0;
            for (int i = 0; i < num_ch; i++) begin
                pan_code[i] <= '0;
            end
        end else if (cs) begin
            if (!wr_n) begin
                case (addr)
                    6'h02, 6'h03:   ps2m[addr[0]] <= din;
                    reg_keyon:      keyon <= din[3:0];
                    reg_loop_adpcm: {adpcm_en, loop} <= din;
                    reg_pan01:      {pan_code[1], pan_code[0]} <= din[5:0];
                    reg_pan23:      {pan_code[3], pan_code[2]} <= din[5:0];
                    reg_mode:       mode <= din[1:0];
                    default: ;
                endcase
            end
            if (!rd_n) begin
                case (addr)
                    6'h00, 6'h01: dout <= pm2s[addr[0]];
                    // status bits read 1 while a channel is still playing
                    reg_status:   dout <= {4'd0, ~over};
                    reg_rom_rd:   dout <= mode[0] ? rom0_data : 8'd0;
                    default:      dout <= 8'd0;
                endcase
            end
        end
    end

    // 0x08..0x27 map onto channel banks 0..3
    always_comb begin
        for (int i = 0; i < num_ch; i++) begin
            ch_we[i] = cs && !wr_n && (addr[5:3] == 3'(i + 1));
        end
    end

    always_comb begin
        for (int i = 0; i < num_ch; i++) begin
            pan_l[i] = pan_left[pan_code[i]];
            pan_r[i] = pan_right[pan_code[i]];
        end
    end

    ch_we_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ch_we));

endmodule

`default_nettype wire

//--- hdl/pcm_channel.sv
`timescale 1ns/1ps
`default_nettype none

module pcm_channel import pcm_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    // register bank write port
    input  logic [2:0]        reg_addr,
    input  logic [7:0]        din,
    input  logic              we,
    // control
    input  logic              keyon,
    input  logic              loop,
    input  logic              adpcm_en,
    input  pan_gain_t         pan_l,
    input  pan_gain_t         pan_r,
    // sample ROM
    input  logic [7:0]        rom_data,
    output logic [rom_aw-1:0] rom_addr,
    output logic              rom_cs,
    // output
    output ch_snd_t           snd_l,
    output ch_snd_t           snd_r,
    output logic              over,
    output logic              sample
);
    logic        [7:0]        mmr [8];
    logic        [rom_aw-1:0] start;
    logic        [15:0]       length;
    logic        [11:0]       pitch;
    logic        [6:0]        volume;

    logic        [16:0]       cnt;
    logic                     cnt_dec;
    logic        [11:0]       pitch_cnt;
    logic        [12:0]       nx_pitch;
    logic                     nib_hi;
    logic        [3:0]        nibble;
    logic signed [7:0]        delta;
    logic signed [7:0]        acc;
    logic signed [7:0]        acc_q;
    logic        [13:0]       vol_l;
    logic        [13:0]       vol_r;
    logic signed [15:0]       mul_l;
    logic signed [15:0]       mul_r;

    assign start  = {mmr[ch_start+2][4:0], mmr[ch_start+1], mmr[ch_start]};
    assign length = {mmr[ch_length+1], mmr[ch_length]};
    assign pitch  = {mmr[ch_pitch+1][3:0], mmr[ch_pitch]};
    assign volume = mmr[ch_volume][6:0];

    assign nx_pitch = {1'b0, pitch_cnt} + 13'd1;
    assign sample   = keyon & cen & nx_pitch[12];
    assign over     = cnt[16] & keyon;
    // low nibble plays first
    assign nibble   = nib_hi ? rom_data[7:4] : rom_data[3:0];

    assign mul_l = acc_q * $signed({1'b0, vol_l[13-:7]});
    assign mul_r = acc_q * $signed({1'b0, vol_r[13-:7]});

    // power of two deltas, sign in bit 3
    always_comb begin
        case (nibble)
            4'h0:    delta = 8'sd0;
            4'h1:    delta = 8'sd1;
            4'h2:    delta = 8'sd2;
            4'h3:    delta = 8'sd4;
            4'h4:    delta = 8'sd8;
            4'h5:    delta = 8'sd16;
            4'h6:    delta = 8'sd32;
            4'h7:    delta = 8'sd64;
            4'h8:    delta = 8'sh80;
            4'h9:    delta = 8'shC0;
            4'hA:    delta = 8'shE0;
            4'hB:    delta = 8'shF0;
            4'hC:    delta = 8'shF8;
            4'hD:    delta = 8'shFC;
            4'hE:    delta = 8'shFE;
            default: delta = 8'shFF;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                mmr[i] <= '0;
            end
        end else if (we) begin
            mmr[reg_addr] <= din;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_addr  <= '0;
            rom_cs    <= 1'b0;
            cnt       <= '0;
            cnt_dec   <= 1'b0;
            pitch_cnt <= '0;
            nib_hi    <= 1'b0;
            acc       <= '0;
        end else begin
            cnt_dec <= 1'b0;
            rom_cs  <= 1'b1;
            // count follows the address one clock later
            if (cnt_dec) begin
                cnt <= cnt - 17'd1;
            end
            if (!keyon) begin
                // first byte is skipped
                rom_addr  <= start + rom_aw'(1);
                cnt       <= {1'b0, length};
                pitch_cnt <= pitch;
                nib_hi    <= 1'b0;
                acc       <= '0;
                rom_cs    <= 1'b0;
            end else if (cen) begin
                if (!cnt[16] && nx_pitch[12]) begin
                    nib_hi <= adpcm_en && !nib_hi;
                    if (nib_hi || !adpcm_en) begin
                        if (cnt == 17'd0 && loop) begin
                            rom_addr <= start;
                            cnt      <= {1'b0, length};
                        end else begin
                            rom_addr <= rom_addr + rom_aw'(1);
                            cnt_dec  <= 1'b1;
                        end
                    end
                    acc <= adpcm_en ? acc + delta : $signed(rom_data);
                end
                pitch_cnt <= nx_pitch[12] ? pitch : nx_pitch[11:0];
                // decay towards zero after the end
                if (over) begin
                    acc <= acc >>> 1;
                end
            end
        end
    end

    // gain stage, two clocks from accumulator or gain change
    always_ff @(posedge clk) begin
        acc_q <= acc;
        vol_l <= volume * pan_l;
        vol_r <= volume * pan_r;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_l <= '0;
            snd_r <= '0;
        end else if (!keyon) begin
            snd_l <= snd_l >>> 1;
            snd_r <= snd_r >>> 1;
        end else begin
            snd_l <= mul_l[15-:12];
            snd_r <= mul_r[15-:12];
        end
    end

    keyoff_no_cs: assert property (@(posedge clk) disable iff (rst) !keyon |=> !rom_cs);

    over_addr_hold: assert property (
        @(posedge clk) disable iff (rst) over |=> $stable(rom_addr)
    );

endmodule

`default_nettype wire

//--- hdl/pcm_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module pcm_mixer import pcm_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              mix_en,
    input  ch_snd_t           ch_snd_l [num_ch],
    input  ch_snd_t           ch_snd_r [num_ch],
    input  logic [num_ch-1:0] ch_sample,
    output mix_snd_t          snd_l,
    output mix_snd_t          snd_r,
    output logic              sample
);
    mix_snd_t sum_l;
    mix_snd_t sum_r;

    assign sample = |ch_sample;

    // four 12-bit voices fit in 14 bits
    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int i = 0; i < num_ch; i++) begin
            sum_l = sum_l + mix_snd_t'(ch_snd_l[i]);
            sum_r = sum_r + mix_snd_t'(ch_snd_r[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_l <= '0;
            snd_r <= '0;
        end else if (mix_en) begin
            snd_l <= sum_l;
            snd_r <= sum_r;
        end else if (cen) begin
            // output off, fade instead of a hard step
            snd_l <= snd_l >>> 1;
            snd_r <= snd_r >>> 1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pcm_sound.sv
`timescale 1ns/1ps
`default_nettype none

module pcm_sound import pcm_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    // main CPU
    input  logic              ma0,
    input  logic              mrdnw,
    input  logic              mcs,
    input  logic [7:0]        mdout,
    output logic [7:0]        mdin,
    // sound CPU
    input  logic [5:0]        addr,
    input  logic              wr_n,
    input  logic              rd_n,
    input  logic              cs,
    input  logic [7:0]        din,
    output logic [7:0]        dout,
    // sample ROMs, one per channel
    output logic [rom_aw-1:0] rom_a_addr,
    input  logic [7:0]        rom_a_data,
    output logic              rom_a_cs,
    output logic [rom_aw-1:0] rom_b_addr,
    input  logic [7:0]        rom_b_data,
    output logic              rom_b_cs,
    output logic [rom_aw-1:0] rom_c_addr,
    input  logic [7:0]        rom_c_data,
    output logic              rom_c_cs,
    output logic [rom_aw-1:0] rom_d_addr,
    input  logic [7:0]        rom_d_data,
    output logic              rom_d_cs,
    // stereo output
    output mix_snd_t          snd_l,
    output mix_snd_t          snd_r,
    output logic              sample
);
    logic [num_ch-1:0] ch_we;
    logic [num_ch-1:0] keyon;
    logic [num_ch-1:0] loop;
    logic [num_ch-1:0] adpcm_en;
    logic [num_ch-1:0] over;
    logic [num_ch-1:0] ch_sample;
    logic              mix_en;
    pan_gain_t         pan_l [num_ch];
    pan_gain_t         pan_r [num_ch];
    ch_snd_t           ch_snd_l [num_ch];
    ch_snd_t           ch_snd_r [num_ch];
    logic [rom_aw-1:0] rom_addr [num_ch];
    logic [7:0]        rom_data [num_ch];
    logic [num_ch-1:0] rom_cs;

    assign rom_data[0] = rom_a_data;
    assign rom_data[1] = rom_b_data;
    assign rom_data[2] = rom_c_data;
    assign rom_data[3] = rom_d_data;

    assign rom_a_addr = rom_addr[0];
    assign rom_b_addr = rom_addr[1];
    assign rom_c_addr = rom_addr[2];
    assign rom_d_addr = rom_addr[3];
    assign {rom_d_cs, rom_c_cs, rom_b_cs, rom_a_cs} = rom_cs;

    pcm_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .ma0       (ma0),
        .mrdnw     (mrdnw),
        .mcs       (mcs),
        .mdout     (mdout),
        .mdin      (mdin),
        .addr      (addr),
        .wr_n      (wr_n),
        .rd_n      (rd_n),
        .cs        (cs),
        .din       (din),
        .dout      (dout),
        .over      (over),
        .rom0_data (rom_a_data),
        .ch_we     (ch_we),
        .keyon     (keyon),
        .loop      (loop),
        .adpcm_en  (adpcm_en),
        .mix_en    (mix_en),
        .pan_l     (pan_l),
        .pan_r     (pan_r)
    );

    // all banks share the low address bits and the data bus
    for (genvar i = 0; i < num_ch; i++) begin : g_ch
        pcm_channel u_ch (
            .clk      (clk),
            .rst      (rst),
            .cen      (cen),
            .reg_addr (addr[2:0]),
            .din      (din),
            .we       (ch_we[i]),
            .keyon    (keyon[i]),
            .loop     (loop[i]),
            .adpcm_en (adpcm_en[i]),
            .pan_l    (pan_l[i]),
            .pan_r    (pan_r[i]),
            .rom_data (rom_data[i]),
            .rom_addr (rom_addr[i]),
            .rom_cs   (rom_cs[i]),
            .snd_l    (ch_snd_l[i]),
            .snd_r    (ch_snd_r[i]),
            .over     (over[i]),
            .sample   (ch_sample[i])
        );
    end

    pcm_mixer u_mixer (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .mix_en    (mix_en),
        .ch_snd_l  (ch_snd_l),
        .ch_snd_r  (ch_snd_r),
        .ch_sample (ch_sample),
        .snd_l     (snd_l),
        .snd_r     (snd_r),
        .sample    (sample)
    );

endmodule

`default_nettype wire

//--- testbench/pcm_sound_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pcm_sound_tb import pcm_pkg::*; ();

    localparam time period   = 40;
    localparam int  max_cmds = 64;
    localparam int  margin   = 200;

    // command opcodes of the pattern file
    localparam logic [3:0] op_end     = 4'h0;
    localparam logic [3:0] op_main_wr = 4'h1;
    localparam logic [3:0] op_main_rd = 4'h2;
    localparam logic [3:0] op_snd_wr  = 4'h3;
    localparam logic [3:0] op_snd_rd  = 4'h4;
    localparam logic [3:0] op_wait    = 4'h5;
    localparam logic [3:0] op_rom_a   = 4'h6;
    localparam logic [3:0] op_stereo  = 4'h7;

    logic              clk;
    logic              rst;
    logic              cen;
    logic              ma0;
    logic              mrdnw;
    logic              mcs;
    logic [7:0]        mdout;
    logic [7:0]        mdin;
    logic [5:0]        addr;
    logic              wr_n;
    logic              rd_n;
    logic              cs;
    logic [7:0]        din;
    logic [7:0]        dout;
    logic [rom_aw-1:0] rom_a_addr;
    logic [rom_aw-1:0] rom_b_addr;
    logic [rom_aw-1:0] rom_c_addr;
    logic [rom_aw-1:0] rom_d_addr;
    logic [7:0]        rom_a_data;
    logic [7:0]        rom_b_data;
    logic [7:0]        rom_c_data;
    logic [7:0]        rom_d_data;
    logic              rom_a_cs;
    logic              rom_b_cs;
    logic              rom_c_cs;
    logic              rom_d_cs;
    mix_snd_t          snd_l;
    mix_snd_t          snd_r;
    logic              sample;

    // op, address, data, expected
    logic [67:0] cmds [max_cmds];
    int          watchdog_cycles;
    logic        armed;

    // shadow of the sound CPU writes
    logic [7:0]        bank [num_ch][8];
    logic [num_ch-1:0] key_reg;
    logic [num_ch-1:0] key_cs;
    logic [rom_aw-1:0] idle_addr [num_ch];
    logic [11:0]       step_cnt [num_ch];
    logic [rom_aw-1:0] port_addr [num_ch];
    logic [num_ch-1:0] port_cs;

    // every address bit reaches the data, one key per port
    function automatic logic [7:0] rom_byte(input int port, input logic [rom_aw-1:0] a);
        logic [7:0] key;
        case (port)
            0:       key = 8'h7c;
            1:       key = 8'h25;
            2:       key = 8'h3c;
            default: key = 8'hc3;
        endcase
        return a[7:0] ^ a[15:8] ^ {3'd0, a[20:16]} ^ key;
    endfunction

    assign rom_a_data = rom_byte(0, rom_a_addr);
    assign rom_b_data = rom_byte(1, rom_b_addr);
    assign rom_c_data = rom_byte(2, rom_c_addr);
    assign rom_d_data = rom_byte(3, rom_d_addr);

    assign port_addr[0] = rom_a_addr;
    assign port_addr[1] = rom_b_addr;
    assign port_addr[2] = rom_c_addr;
    assign port_addr[3] = rom_d_addr;
    assign port_cs      = {rom_d_cs, rom_c_cs, rom_b_cs, rom_a_cs};

    pcm_sound uut (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .ma0        (ma0),
        .mrdnw      (mrdnw),
        .mcs        (mcs),
        .mdout      (mdout),
        .mdin       (mdin),
        .addr       (addr),
        .wr_n       (wr_n),
        .rd_n       (rd_n),
        .cs         (cs),
        .din        (din),
        .dout       (dout),
        .rom_a_addr (rom_a_addr),
        .rom_a_data (rom_a_data),
        .rom_a_cs   (rom_a_cs),
        .rom_b_addr (rom_b_addr),
        .rom_b_data (rom_b_data),
        .rom_b_cs   (rom_b_cs),
        .rom_c_addr (rom_c_addr),
        .rom_c_data (rom_c_data),
        .rom_c_cs   (rom_c_cs),
        .rom_d_addr (rom_d_addr),
        .rom_d_data (rom_d_data),
        .rom_d_cs   (rom_d_cs),
        .snd_l      (snd_l),
        .snd_r      (snd_r),
        .sample     (sample)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // clock enable on every other cycle
    always @(negedge clk) begin
        cen <= ~cen;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            fail_now($sformatf("error: %t %s is %h, expected %h",
                               $time, what, got, expected));
        end
    endtask

    function automatic logic [rom_aw-1:0] start_of(input int ch);
        return {bank[ch][ch_start+2][4:0], bank[ch][ch_start+1], bank[ch][ch_start]};
    endfunction

    function automatic logic [11:0] pitch_of(input int ch);
        return {bank[ch][ch_pitch+1][3:0], bank[ch][ch_pitch]};
    endfunction

    // a keyed voice steps on the cen pulse that takes its counter past 4095
    function automatic logic step_due();
        logic due;
        due = 1'b0;
        for (int i = 0; i < num_ch; i++) begin
            due |= key_reg[i] && cen && step_cnt[i] == 12'hfff;
        end
        return due;
    endfunction

    // follow the register writes and the pitch counters from the bus
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            key_reg <= '0;
            key_cs  <= '0;
            for (int i = 0; i < num_ch; i++) begin
                for (int j = 0; j < 8; j++) begin
                    bank[i][j] <= '0;
                end
                idle_addr[i] <= '0;
                step_cnt[i]  <= '0;
            end
        end else begin
            check_value("sample", 32'(sample), 32'(step_due()));
            key_cs <= key_reg;
            for (int i = 0; i < num_ch; i++) begin
                idle_addr[i] <= start_of(i) + rom_aw'(1);
                if (!key_reg[i]) begin
                    step_cnt[i] <= pitch_of(i);
                end else if (cen) begin
                    step_cnt[i] <= (step_cnt[i] == 12'hfff) ? pitch_of(i)
                                                            : step_cnt[i] + 12'd1;
                end
            end
            if (cs && !wr_n) begin
                if (addr == reg_keyon) begin
                    key_reg <= din[3:0];
                end
                if (addr[5:3] >= 3'd1 && addr[5:3] <= 3'(num_ch)) begin
                    bank[addr[5:3] - 3'd1][addr[2:0]] <= din;
                end
            end
        end
    end

    // chip selects and idle addresses of all four ROM ports
    always @(negedge clk) begin
        if (!rst) begin
            check_value("rom chip selects", 32'(port_cs), 32'(key_cs));
            for (int i = 0; i < num_ch; i++) begin
                if (!key_cs[i]) begin
                    check_value($sformatf("rom address of channel %0d", i),
                                32'(port_addr[i]), 32'(idle_addr[i]));
                end
            end
        end
    end

    // one clock with mcs high, called on a falling edge
    task automatic main_access(input logic sel, input logic rd, input logic [7:0] data);
        ma0   = sel;
        mrdnw = rd;
        mdout = data;
        mcs   = 1'b1;
        @(negedge clk);
        mcs   = 1'b0;
        mrdnw = 1'b1;
    endtask

    task automatic sound_write(input logic [5:0] a, input logic [7:0] data);
        addr = a;
        din  = data;
        cs   = 1'b1;
        wr_n = 1'b0;
        @(negedge clk);
        cs   = 1'b0;
        wr_n = 1'b1;
    endtask

    task automatic sound_read(input logic [5:0] a);
        addr = a;
        cs   = 1'b1;
        rd_n = 1'b0;
        @(negedge clk);
        cs   = 1'b0;
        rd_n = 1'b1;
    endtask

    task automatic run_command(input logic [67:0] cmd);
        logic [3:0]  op;
        logic [7:0]  a;
        logic [23:0] d;
        logic [31:0] e;
        op = cmd[67:64];
        a  = cmd[63:56];
        d  = cmd[55:32];
        e  = cmd[31:0];
        case (op)
            op_main_wr: main_access(a[0], 1'b0, d[7:0]);
            op_main_rd: begin
                main_access(a[0], 1'b1, 8'h00);
                check_value("mdin", {24'd0, mdin}, e);
            end
            op_snd_wr:  sound_write(a[5:0], d[7:0]);
            op_snd_rd: begin
                sound_read(a[5:0]);
                check_value($sformatf("dout at 0x%h", a[5:0]), {24'd0, dout}, e);
            end
            op_wait:    repeat (d) @(negedge clk);
            op_rom_a:   check_value("rom_a_addr", 32'(rom_a_addr), e);
            op_stereo:  check_value("snd_l and snd_r", {2'd0, snd_l, 2'd0, snd_r},
                                    {2'd0, e[29:16], 2'd0, e[13:0]});
            default:    fail_now($sformatf("unknown command %h in the pattern file", op));
        endcase
    endtask

    initial begin
        int n_cmds;
        int wait_sum;
        $timeformat(-9, 0, " ns", 0);
        rst   = 1'b1;
        cen   = 1'b0;
        ma0   = 1'b0;
        mrdnw = 1'b1;
        mcs   = 1'b0;
        mdout = 8'h00;
        addr  = 6'h00;
        wr_n  = 1'b1;
        rd_n  = 1'b1;
        cs    = 1'b0;
        din   = 8'h00;
        armed = 1'b0;
        for (int i = 0; i < max_cmds; i++) begin
            cmds[i] = '0;
        end
        $readmemh("testbench/pcm_sound_patterns.txt", cmds);
        n_cmds   = 0;
        wait_sum = 0;
        while (n_cmds < max_cmds && cmds[n_cmds][67:64] != op_end) begin
            if (cmds[n_cmds][67:64] == op_wait) begin
                wait_sum += int'(cmds[n_cmds][55:32]);
            end
            n_cmds++;
        end
        assert (n_cmds > 0) else begin
            fail_now("no commands could be read from the pattern file");
        end
        // every command takes at most one clock besides its waits
        watchdog_cycles = wait_sum + n_cmds + margin;
        armed = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_cmds; i++) begin
            run_command(cmds[i]);
        end
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        wait (armed === 1'b1);
        #(watchdog_cycles * period);
        fail_now($sformatf("timeout: the patterns did not finish within %0d clock cycles",
                           watchdog_cycles));
    end

endmodule

`default_nettype wire

//--- testbench/pcm_sound_patterns.txt
// op_addr_data_expect, op 1 main wr, 2 main rd, 3 sound wr, 4 sound rd, 5 wait data clocks
// 6 check rom_a address, 7 check stereo {snd_l, snd_r} in 16-bit halves, 0 ends the list
// mailbox both ways
1_01_0000c3_00000000
4_01_000000_000000c3
3_02_000096_00000000
2_00_000000_00000096
// channel 0: pitch ff0, length 3, start 12341a, volume 7f, pan ch0 center, ch1 code 2
3_08_0000f0_00000000
3_09_00000f_00000000
3_0a_000003_00000000
3_0c_00001a_00000000
3_0d_000034_00000000
3_0e_000012_00000000
3_0f_00007f_00000000
3_2c_000014_00000000
// rom readback only with mode bit0
6_00_000000_0012341b
4_2e_000000_00000000
3_2f_000001_00000000
4_2e_000000_00000041
4_29_000000_0000000f
// pcm play without loop, one step every 32 clocks
3_28_000001_00000000
5_00_000030_00000000
6_00_000000_0012341c
4_29_000000_0000000f
5_00_00007f_00000000
6_00_000000_0012341f
4_29_000000_0000000e
// adpcm advances every second step
3_28_000000_00000000
3_2a_000010_00000000
3_28_000001_00000000
5_00_0000b0_00000000
6_00_000000_0012341d
// loop with length 0 on channels 0 and 1, then mix
3_28_000000_00000000
3_0a_000000_00000000
3_2a_000003_00000000
3_10_0000f0_00000000
3_11_00000f_00000000
3_17_000050_00000000
3_28_000003_00000000
5_00_000030_00000000
6_00_000000_0012341a
4_29_000000_0000000f
3_2f_000003_00000000
5_00_00002e_00000000
7_00_000000_020a01ae
4_2e_000000_00000040
// output off fades to zero
3_2f_000001_00000000
5_00_000028_00000000
7_00_000000_00000000
0_00_000000_00000000

//--- pcm_sound.f
hdl/pcm_pkg.sv
hdl/pcm_regs.sv
hdl/pcm_channel.sv
hdl/pcm_mixer.sv
hdl/pcm_sound.sv
testbench/pcm_sound_tb.sv

//--- Bender.yml
package:
  name: pcm_sound

sources:
  - hdl/pcm_pkg.sv
  - hdl/pcm_regs.sv
  - hdl/pcm_channel.sv
  - hdl/pcm_mixer.sv
  - hdl/pcm_sound.sv
  - target: test
    files:
      - testbench/pcm_sound_tb.sv
